//--- tb.f
+incdir+src
src/ramtest_pkg.sv
src/buf_if.sv
src/ctrl_regs.sv
src/pipe_in_buf.sv
src/pipe_out_buf.sv
src/ddr3_mover.sv
src/ramtest_top.sv
tests/app_mem_model.sv
tests/ramtest_checker.sv
tests/tb_ramtest.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        = tb_ramtest
FILELIST   = tb.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/tb_ramtest.sv
//--------------------------------------------------
// RAM test testbench
// Host pipe stimulus, loopback scoreboard, reporting
//--------------------------------------------------
`timescale 1ns/1ps
`include "ramtest_params.svh"

module tb_ramtest;
	import ramtest_pkg::*;

	logic                    okClk;
	logic                    rst_n;
	logic                    ctrl_wr;
	logic [31:0]             ctrl_data;
	logic                    pi_write;
	logic [`RT_HOST_W-1:0]   pi_data;
	logic                    pi_ready;
	logic                    po_read;
	logic [`RT_HOST_W-1:0]   po_data;
	logic                    po_ready;
	logic [7:0]              led;
	logic                    calib_done;
	logic                    app_en;
	app_cmd_e                app_cmd;
	logic [`RT_ADDR_W-1:0]   app_addr;
	logic                    app_rdy;
	logic                    app_wdf_wren;
	logic [`RT_BEAT_W-1:0]   app_wdf_data;
	logic                    app_wdf_end;
	logic [`RT_BEAT_W/8-1:0] app_wdf_mask;
	logic                    app_wdf_rdy;
	logic [`RT_BEAT_W-1:0]   app_rd_data;
	logic                    app_rd_data_valid;
	logic [31:0]             rnd;
	logic [31:0]             expect_q[$];
	int                      errors;
	int                      checks;
	int                      err_mark;

	ramtest_top dut (.*);
	app_mem_model u_mem (.*);

	initial okClk = 1'b0;
	always #2 okClk = ~okClk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report(input string name);
		$display("[%0t] %s finished, %0d errors", $time, name, errors - err_mark);
		err_mark = errors;
	endtask

	// Sampled on the falling edge
	task automatic wait_ready(input bit out_side);
		int n;
		n = 0;
		@(negedge okClk);
		while ((out_side ? po_ready : pi_ready) !== 1'b1) begin
			@(negedge okClk);
			n++;
			if (n > 5000) begin
				$display("Timeout waiting for %s", out_side ? "po_ready" : "pi_ready");
				$display("Test FAILED");
				$finish;
			end
		end
	endtask

	task automatic write_ctrl(input logic [31:0] v);
		@(posedge okClk);
		ctrl_wr   <= 1'b1;
		ctrl_data <= v;
		@(posedge okClk);
		ctrl_wr <= 1'b0;
		@(negedge okClk);
		check_val("led[3]", led[3], v[0]);
		check_val("led[2]", led[2], v[1]);
		check_val("led[0]", led[0], calib_done);
	endtask

	task automatic push_words(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge okClk);
			rnd = xorshift32(rnd);
			pi_write <= 1'b1;
			pi_data  <= rnd;
			expect_q.push_back(rnd);
		end
		@(posedge okClk);
		pi_write <= 1'b0;
	endtask

	// Head word is compared before the edge that pops it
	task automatic pop_words(input int n);
		@(posedge okClk);
		po_read <= 1'b1;
		for (int i = 0; i < n; i++) begin
			@(negedge okClk);
			check_val("po_data", po_data, expect_q.pop_front());
			@(posedge okClk);
		end
		po_read <= 1'b0;
	endtask

	initial begin
		rst_n = 1'b0;
		ctrl_wr = 1'b0;
		ctrl_data = '0;
		pi_write = 1'b0;
		pi_data = '0;
		po_read = 1'b0;
		calib_done = 1'b0;
		rnd = 32'h92ed5f97;
		errors = 0;
		checks = 0;
		err_mark = 0;
		repeat (2) @(posedge okClk);
		rst_n <= 1'b1;

		// ------------------------------------------------
		// Reset state
		@(negedge okClk);
		check_val("pi_ready", pi_ready, 0);
		check_val("po_ready", po_ready, 0);
		check_val("led", led, 8'hF0);
		@(posedge okClk);
		calib_done <= 1'b1;
		repeat (4) @(negedge okClk);
		check_val("pi_ready", pi_ready, 1);
		check_val("app_en", app_en, 0);
		report("reset state");

		// Input throttle, writes disabled
		for (int i = 0; i < 880; i++) begin
			push_words(1);
			@(posedge okClk);
			@(negedge okClk);
			check_val("pi_ready", pi_ready, (i + 1) <= 876);
		end
		write_ctrl(32'h4);
		write_ctrl(32'h0);
		expect_q.delete();
		report("input throttle");

		// ------------------------------------------------
		// Loopback of four blocks
		write_ctrl(32'h3);
		for (int b = 0; b < 4; b++) begin
			wait_ready(1'b0);
			push_words(`RT_BLOCK_WORDS);
		end
		for (int b = 0; b < 4; b++) begin
			wait_ready(1'b1);
			pop_words(`RT_BLOCK_WORDS);
		end
		repeat (2) @(negedge okClk);
		check_val("po_ready", po_ready, 0);
		report("loopback order");

		// Output throttle falls one cycle after the pop
		push_words(`RT_BLOCK_WORDS);
		wait_ready(1'b1);
		pop_words(1);
		@(negedge okClk);
		check_val("po_ready", po_ready, 1);
		@(negedge okClk);
		check_val("po_ready", po_ready, 0);
		pop_words(`RT_BLOCK_WORDS - 1);
		report("output throttle");

		// Soft reset drops a block waiting in the output buffer
		push_words(`RT_BLOCK_WORDS);
		wait_ready(1'b1);
		write_ctrl(32'h4);
		write_ctrl(32'h3);
		expect_q.delete();
		repeat (3) @(negedge okClk);
		check_val("po_ready", po_ready, 0);
		check_val("pi_ready", pi_ready, 1);
		push_words(`RT_BLOCK_WORDS);
		wait_ready(1'b1);
		pop_words(`RT_BLOCK_WORDS);
		report("soft reset");

		// LED status, last write with calibration lost
		write_ctrl(32'h1);
		write_ctrl(32'h2);
		@(posedge okClk);
		calib_done <= 1'b0;
		write_ctrl(32'h0);
		report("led status");

		// Failures of the bound protocol assertions
		errors += dut.chk.fail_cnt;

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- tests/ramtest_checker.sv
//--------------------------------------------------
// Application port protocol assertions
//--------------------------------------------------
`timescale 1ns/1ps
`include "ramtest_params.svh"

module ramtest_checker (
	input logic                    okClk,
	input logic                    rst_n,
	input logic                    calib_done,
	input logic                    app_en,
	input ramtest_pkg::app_cmd_e   app_cmd,
	input logic [`RT_ADDR_W-1:0]   app_addr,
	input logic                    app_rdy,
	input logic                    app_wdf_wren,
	input logic [`RT_BEAT_W-1:0]   app_wdf_data,
	input logic                    app_wdf_end,
	input logic [`RT_BEAT_W/8-1:0] app_wdf_mask,
	input logic                    app_wdf_rdy
);

	// Failed assertions so far
	int unsigned fail_cnt = 0;

	// Command held until accepted
	cmd_hold: assert property (@(posedge okClk) disable iff (!rst_n)
		app_en && !app_rdy |=> app_en && $stable(app_cmd) && $stable(app_addr))
		else begin
			fail_cnt++;
			$error("app_en dropped or changed before app_rdy");
		end

	// Write data held until accepted
	wdf_hold: assert property (@(posedge okClk) disable iff (!rst_n)
		app_wdf_wren && !app_wdf_rdy |=> app_wdf_wren && $stable(app_wdf_data))
		else begin
			fail_cnt++;
			$error("app_wdf_wren dropped or data changed before app_wdf_rdy");
		end

	// Single-beat bursts with no byte mask
	wdf_end_single: assert property (@(posedge okClk) disable iff (!rst_n)
		app_wdf_end == app_wdf_wren && app_wdf_mask == '0)
		else begin
			fail_cnt++;
			$error("app_wdf_end differs from app_wdf_wren or app_wdf_mask not zero");
		end

	no_cmd_uncal: assert property (@(posedge okClk) disable iff (!rst_n)
		app_en |-> calib_done)
		else begin
			fail_cnt++;
			$error("app_en before calib_done");
		end

endmodule

bind ramtest_top ramtest_checker chk (.*);

//--- tests/app_mem_model.sv
//--------------------------------------------------
// Behavioral memory on the application port
// Random ready stalls, in-order read return
//--------------------------------------------------
`timescale 1ns/1ps
`include "ramtest_params.svh"

module app_mem_model (
	input  logic                  okClk,
	input  logic                  rst_n,
	input  logic                  app_en,
	input  ramtest_pkg::app_cmd_e app_cmd,
	input  logic [`RT_ADDR_W-1:0] app_addr,
	input  logic                  app_wdf_wren,
	input  logic [`RT_BEAT_W-1:0] app_wdf_data,
	output logic                  app_rdy,
	output logic                  app_wdf_rdy,
	output logic [`RT_BEAT_W-1:0] app_rd_data,
	output logic                  app_rd_data_valid
);
	import ramtest_pkg::*;

	logic [`RT_BEAT_W-1:0] mem [`RT_MEM_BEATS];
	logic [31:0]           rnd_q;
	int unsigned           cycle_q;
	int unsigned           last_due_q;
	int unsigned           due_q[$];
	logic [7:0]            addr_q[$];

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	always @(posedge okClk or negedge rst_n) begin : model
		int unsigned due;
		if (!rst_n) begin
			rnd_q             <= 32'h92ed5f97;
			cycle_q           <= 0;
			last_due_q        <= 0;
			app_rdy           <= 1'b0;
			app_wdf_rdy       <= 1'b0;
			app_rd_data_valid <= 1'b0;
			due_q.delete();
			addr_q.delete();
		end else begin
			rnd_q       <= xorshift32(rnd_q);
			cycle_q     <= cycle_q + 1;
			app_rdy     <= (rnd_q[1:0] != 2'b00);
			app_wdf_rdy <= (rnd_q[3:2] != 2'b00);
			// Beat index sits above the three byte bits
			if (app_wdf_wren && app_wdf_rdy) begin
				mem[app_addr[10:3]] <= app_wdf_data;
			end
			app_rd_data_valid <= 1'b0;
			if (due_q.size() > 0 && due_q[0] <= cycle_q) begin
				app_rd_data_valid <= 1'b1;
				app_rd_data       <= mem[addr_q.pop_front()];
				void'(due_q.pop_front());
			end
			// Latency 2 to 6 cycles, never ahead of an earlier read
			if (app_en && app_rdy && app_cmd == APP_READ) begin
				due = cycle_q + 2 + (rnd_q[15:8] % 5);
				if (due <= last_due_q) begin
					due = last_due_q + 1;
				end
				due_q.push_back(due);
				addr_q.push_back(app_addr[10:3]);
				last_due_q <= due;
			end
		end
	end

endmodule

//--- src/ramtest_top.sv
//--------------------------------------------------
// RAM test top level
// Host pipes, control register and memory mover
//--------------------------------------------------
`timescale 1ns/1ps
`include "ramtest_params.svh"

module ramtest_top (
	input  logic                    okClk,
	input  logic                    rst_n,
	input  logic                    ctrl_wr,
	input  logic [31:0]             ctrl_data,
	input  logic                    pi_write,
	input  logic [`RT_HOST_W-1:0]   pi_data,
	output logic                    pi_ready,
	input  logic                    po_read,
	output logic [`RT_HOST_W-1:0]   po_data,
	output logic                    po_ready,
	output logic [7:0]              led,
	input  logic                    calib_done,
	output logic                    app_en,
	output ramtest_pkg::app_cmd_e   app_cmd,
	output logic [`RT_ADDR_W-1:0]   app_addr,
	input  logic                    app_rdy,
	output logic                    app_wdf_wren,
	output logic [`RT_BEAT_W-1:0]   app_wdf_data,
	output logic                    app_wdf_end,
	output logic [`RT_BEAT_W/8-1:0] app_wdf_mask,
	input  logic                    app_wdf_rdy,
	input  logic [`RT_BEAT_W-1:0]   app_rd_data,
	input  logic                    app_rd_data_valid
);

	logic                  reads_en;
	logic                  writes_en;
	logic                  soft_rst;
	logic [`RT_WCNT_W-1:0] in_words;
	logic [`RT_WCNT_W-1:0] out_words;

	in_buf_if  ib_bus ();
	out_buf_if ob_bus ();

	ctrl_regs u_regs (
		.okClk(okClk), .rst_n(rst_n), .ctrl_wr(ctrl_wr), .ctrl_data(ctrl_data),
		.calib_done(calib_done), .wdf_rdy(app_wdf_rdy),
		.in_words(in_words), .out_words(out_words),
		.reads_en(reads_en), .writes_en(writes_en), .soft_rst(soft_rst),
		.pi_ready(pi_ready), .po_ready(po_ready), .led(led)
	);

	pipe_in_buf u_in (
		.okClk(okClk), .rst_n(rst_n), .clr(soft_rst), .wr(pi_write), .din(pi_data),
		.words(in_words), .ib(ib_bus.src)
	);

	pipe_out_buf u_out (
		.okClk(okClk), .rst_n(rst_n), .clr(soft_rst), .rd(po_read), .dout(po_data),
		.words(out_words), .ob(ob_bus.snk)
	);

	ddr3_mover u_mover (
		.okClk(okClk), .rst_n(rst_n), .clr(soft_rst), .calib_done(calib_done),
		.reads_en(reads_en), .writes_en(writes_en),
		.app_rdy(app_rdy), .app_wdf_rdy(app_wdf_rdy),
		.app_rd_data(app_rd_data), .app_rd_data_valid(app_rd_data_valid),
		.app_en(app_en), .app_cmd(app_cmd), .app_addr(app_addr),
		.app_wdf_wren(app_wdf_wren), .app_wdf_data(app_wdf_data),
		.app_wdf_end(app_wdf_end), .app_wdf_mask(app_wdf_mask),
		.ib(ib_bus.snk), .ob(ob_bus.src)
	);

endmodule

//--- src/ddr3_mover.sv
//--------------------------------------------------
// Memory mover
// Copies beats to memory and reads them back in order
//--------------------------------------------------
`timescale 1ns/1ps
`include "ramtest_params.svh"

module ddr3_mover (
	input  logic                    okClk,
	input  logic                    rst_n,
	input  logic                    clr,
	input  logic                    calib_done,
	input  logic                    reads_en,
	input  logic                    writes_en,
	input  logic                    app_rdy,
	input  logic                    app_wdf_rdy,
	input  logic [`RT_BEAT_W-1:0]   app_rd_data,
	input  logic                    app_rd_data_valid,
	output logic                    app_en,
	output ramtest_pkg::app_cmd_e   app_cmd,
	output logic [`RT_ADDR_W-1:0]   app_addr,
	output logic                    app_wdf_wren,
	output logic [`RT_BEAT_W-1:0]   app_wdf_data,
	output logic                    app_wdf_end,
	output logic [`RT_BEAT_W/8-1:0] app_wdf_mask,
	in_buf_if.snk                   ib,
	out_buf_if.src                  ob
);
	import ramtest_pkg::*;

	mover_state_e             state_q;
	logic [`RT_MEM_PTR_W-1:0] wr_ptr_q;
	logic [`RT_MEM_PTR_W-1:0] rd_ptr_q;
	logic [`RT_MEM_PTR_W-1:0] pending;
	logic [`RT_BCNT_W-1:0]    inflight_q;
	logic [`RT_BCNT_W-1:0]    inflight_nxt;
	logic [`RT_BCNT_W-1:0]    stale_q;
	logic [`RT_BCNT_W-1:0]    stale_nxt;
	logic [`RT_BCNT_W:0]      room_need;
	logic                     pri_wr_q;
	logic                     abort_q;
	logic                     can_write;
	logic                     can_read;
	logic                     go_write;
	logic                     go_read;
	logic                     wr_done;
	logic                     rd_acc;

	// Byte-style address, eight per beat
	function automatic logic [`RT_ADDR_W-1:0] beat_addr(input logic [`RT_MEM_PTR_W-1:0] p);
		beat_addr = '0;
		beat_addr[`RT_MEM_PTR_W+1:3] = p[`RT_MEM_PTR_W-2:0];
	endfunction

	//--------------------------------------------------
	// Issue decision
	//--------------------------------------------------
	// Lap bit tells a full region from an empty one
	assign pending   = wr_ptr_q - rd_ptr_q;
	assign room_need = ob.count + inflight_q + 1'b1;
	assign can_write = writes_en && !ib.empty && (pending != `RT_MEM_BEATS) && !clr;
	assign can_read  = reads_en && (pending != '0) && !ob.full
		&& (room_need <= `RT_OUT_BEATS) && !clr;
	// Alternate turns, but drain a half-full input buffer first
	assign go_write  = calib_done && can_write
		&& (pri_wr_q || !can_read || ib.count >= `RT_IN_BEATS / 2);
	assign go_read   = calib_done && can_read && !go_write;

	assign ib.re   = (state_q == IDLE) && go_write;
	assign wr_done = (state_q == WR_CMD || state_q == WR_DATA)
		&& !(app_en && !app_rdy) && !(app_wdf_wren && !app_wdf_rdy);
	assign rd_acc  = (state_q == RD_CMD) && app_rdy;

	// Reads issued before a soft reset return stale beats and are dropped
	always_comb begin
		inflight_nxt = inflight_q + rd_acc - app_rd_data_valid;
		stale_nxt = stale_q;
		if (app_rd_data_valid && stale_q != '0) begin
			stale_nxt = stale_nxt - 1'b1;
		end
		if (rd_acc && abort_q) begin
			stale_nxt = stale_nxt + 1'b1;
		end
		if (clr) begin
			stale_nxt = inflight_nxt;
		end
	end

	assign ob.we        = app_rd_data_valid && (stale_q == '0) && !clr;
	assign ob.data      = app_rd_data;
	assign app_wdf_end  = app_wdf_wren;
	assign app_wdf_mask = '0;

	// Command and write payload, held while pending
	always_ff @(posedge okClk) begin
		if (state_q == IDLE && go_write) begin
			app_cmd      <= APP_WRITE;
			app_addr     <= beat_addr(wr_ptr_q);
			app_wdf_data <= ib.data;
		end else if (state_q == IDLE && go_read) begin
			app_cmd  <= APP_READ;
			app_addr <= beat_addr(rd_ptr_q);
		end
	end

	//--------------------------------------------------
	// FSM and pointers
	//--------------------------------------------------
	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			state_q      <= IDLE;
			app_en       <= 1'b0;
			app_wdf_wren <= 1'b0;
			wr_ptr_q     <= '0;
			rd_ptr_q     <= '0;
			inflight_q   <= '0;
			stale_q      <= '0;
			pri_wr_q     <= 1'b1;
			abort_q      <= 1'b0;
		end else begin
			inflight_q <= inflight_nxt;
			stale_q    <= stale_nxt;
			case (state_q)
				IDLE: begin
					if (go_write) begin
						state_q      <= WR_CMD;
						app_en       <= 1'b1;
						app_wdf_wren <= 1'b1;
						pri_wr_q     <= 1'b0;
					end else if (go_read) begin
						state_q  <= RD_CMD;
						app_en   <= 1'b1;
						pri_wr_q <= 1'b1;
					end
				end
				WR_CMD, WR_DATA: begin
					// Command and data accepted independently
					if (app_rdy) begin
						app_en <= 1'b0;
					end
					if (app_wdf_rdy) begin
						app_wdf_wren <= 1'b0;
					end
					if (wr_done) begin
						state_q <= IDLE;
					end else if (app_en && !app_rdy) begin
						state_q <= WR_CMD;
					end else begin
						state_q <= WR_DATA;
					end
				end
				RD_CMD: begin
					if (app_rdy) begin
						app_en  <= 1'b0;
						state_q <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
			// A transaction caught by soft reset does not move the pointers
			if (state_q == IDLE) begin
				abort_q <= 1'b0;
			end else if (clr) begin
				abort_q <= 1'b1;
			end
			if (clr) begin
				wr_ptr_q <= '0;
				rd_ptr_q <= '0;
			end else begin
				if (wr_done && !abort_q) begin
					wr_ptr_q <= wr_ptr_q + 1'b1;
				end
				if (rd_acc && !abort_q) begin
					rd_ptr_q <= rd_ptr_q + 1'b1;
				end
			end
		end
	end

endmodule

//--- src/pipe_out_buf.sv
//--------------------------------------------------
// Output pipe buffer
// Unpacks memory beats into host words
//--------------------------------------------------
`timescale 1ns/1ps
`include "ramtest_params.svh"

module pipe_out_buf (
	input  logic                  okClk,
	input  logic                  rst_n,
	input  logic                  clr,
	input  logic                  rd,
	output logic [`RT_HOST_W-1:0] dout,
	output logic [`RT_WCNT_W-1:0] words,
	out_buf_if.snk                ob
);

	logic [`RT_BEAT_W-1:0]    mem [`RT_OUT_BEATS];
	logic [`RT_BEAT_W-1:0]    head;
	logic [`RT_IDX_W-1:0]     idx_q;
	logic [`RT_BUF_PTR_W-1:0] wptr_q;
	logic [`RT_BUF_PTR_W-1:0] rptr_q;
	logic [`RT_BCNT_W-1:0]    bcnt_q;
	logic                     pop;

	// Beat is freed with its last host word
	assign pop = rd && (idx_q == `RT_IDX_W'(`RT_WORDS_PER_BEAT - 1));

	always_ff @(posedge okClk) begin
		if (ob.we) begin
			mem[wptr_q] <= ob.data;
		end
	end

	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			idx_q  <= '0;
			wptr_q <= '0;
			rptr_q <= '0;
			bcnt_q <= '0;
		end else if (clr) begin
			idx_q  <= '0;
			wptr_q <= '0;
			rptr_q <= '0;
			bcnt_q <= '0;
		end else begin
			if (rd) begin
				idx_q <= idx_q + 1'b1;
			end
			if (ob.we) begin
				wptr_q <= wptr_q + 1'b1;
			end
			if (pop) begin
				rptr_q <= rptr_q + 1'b1;
			end
			case ({ob.we, pop})
				2'b10:   bcnt_q <= bcnt_q + 1'b1;
				2'b01:   bcnt_q <= bcnt_q - 1'b1;
				default: ;
			endcase
		end
	end

	// Head word, lowest lane first
	assign head = mem[rptr_q];
	assign dout = head[idx_q*`RT_HOST_W +: `RT_HOST_W];

	assign ob.count = bcnt_q;
	assign ob.full  = (bcnt_q == `RT_BCNT_W'(`RT_OUT_BEATS));
	assign words    = {bcnt_q, {`RT_IDX_W{1'b0}}} - idx_q;

endmodule

//--- src/pipe_in_buf.sv
//--------------------------------------------------
// Input pipe buffer
// Packs eight host words into one memory beat
//--------------------------------------------------
`timescale 1ns/1ps
`include "ramtest_params.svh"

module pipe_in_buf (
	input  logic                  okClk,
	input  logic                  rst_n,
	input  logic                  clr,
	input  logic                  wr,
	input  logic [`RT_HOST_W-1:0] din,
	output logic [`RT_WCNT_W-1:0] words,
	in_buf_if.src                 ib
);

	logic [`RT_BEAT_W-1:0]    mem [`RT_IN_BEATS];
	logic [`RT_BEAT_W-1:0]    pack_q;
	logic [`RT_IDX_W-1:0]     idx_q;
	logic [`RT_BUF_PTR_W-1:0] wptr_q;
	logic [`RT_BUF_PTR_W-1:0] rptr_q;
	logic [`RT_BCNT_W-1:0]    bcnt_q;
	logic                     beat_done;

	// Eighth word of a beat
	assign beat_done = wr && (idx_q == `RT_IDX_W'(`RT_WORDS_PER_BEAT - 1));

	// First word lands in the lowest lane
	always_ff @(posedge okClk) begin
		if (wr) begin
			pack_q[idx_q*`RT_HOST_W +: `RT_HOST_W] <= din;
		end
		if (beat_done) begin
			mem[wptr_q] <= {din, pack_q[`RT_BEAT_W-`RT_HOST_W-1:0]};
		end
	end

	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			idx_q  <= '0;
			wptr_q <= '0;
			rptr_q <= '0;
			bcnt_q <= '0;
		end else if (clr) begin
			idx_q  <= '0;
			wptr_q <= '0;
			rptr_q <= '0;
			bcnt_q <= '0;
		end else begin
			// Index wraps to zero after the eighth word
			if (wr) begin
				idx_q <= idx_q + 1'b1;
			end
			if (beat_done) begin
				wptr_q <= wptr_q + 1'b1;
			end
			if (ib.re) begin
				rptr_q <= rptr_q + 1'b1;
			end
			case ({beat_done, ib.re})
				2'b10:   bcnt_q <= bcnt_q + 1'b1;
				2'b01:   bcnt_q <= bcnt_q - 1'b1;
				default: ;
			endcase
		end
	end

	assign ib.data  = mem[rptr_q];
	assign ib.count = bcnt_q;
	assign ib.empty = (bcnt_q == '0);

	// Whole beats plus the partial one
	assign words = {bcnt_q, {`RT_IDX_W{1'b0}}} + idx_q;

endmodule

//--- src/ctrl_regs.sv
//--------------------------------------------------
// Control register block
// Enables, soft reset, block throttle and LEDs
//--------------------------------------------------
`timescale 1ns/1ps
`include "ramtest_params.svh"

module ctrl_regs (
	input  logic                  okClk,
	input  logic                  rst_n,
	input  logic                  ctrl_wr,
	input  logic [31:0]           ctrl_data,
	input  logic                  calib_done,
	input  logic                  wdf_rdy,
	input  logic [`RT_WCNT_W-1:0] in_words,
	input  logic [`RT_WCNT_W-1:0] out_words,
	output logic                  reads_en,
	output logic                  writes_en,
	output logic                  soft_rst,
	output logic                  pi_ready,
	output logic                  po_ready,
	output logic [7:0]            led
);

	logic [2:0] ctrl_q;

	// Control word, bit 2 is a level
	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_q <= '0;
		end else if (ctrl_wr) begin
			ctrl_q <= ctrl_data[2:0];
		end
	end

	assign reads_en  = ctrl_q[0];
	assign writes_en = ctrl_q[1];
	assign soft_rst  = ctrl_q[2];

	//--------------------------------------------------
	// Block throttle
	//--------------------------------------------------
	// Room for one more block, less headroom for count lag
	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			pi_ready <= 1'b0;
			po_ready <= 1'b0;
		end else begin
			pi_ready <= (in_words <= (`RT_IN_DEPTH - `RT_HEADROOM - `RT_BLOCK_WORDS));
			po_ready <= (out_words >= `RT_BLOCK_WORDS);
		end
	end

	// Upper nibble always lit
	assign led = {4'hF, reads_en, writes_en, wdf_rdy, calib_done};

endmodule

//--- src/buf_if.sv
//--------------------------------------------------
// Buffer interfaces
// Input-buffer read side and output-buffer write side
//--------------------------------------------------
`timescale 1ns/1ps
`include "ramtest_params.svh"

// Head beat of the input buffer, fall-through
interface in_buf_if;
	logic                  re;
	logic [`RT_BEAT_W-1:0] data;
	logic [`RT_BCNT_W-1:0] count;
	logic                  empty;

	modport src (input re, output data, output count, output empty);
	modport snk (output re, input data, input count, input empty);
endinterface

// Beat push into the output buffer
interface out_buf_if;
	logic                  we;
	logic [`RT_BEAT_W-1:0] data;
	logic [`RT_BCNT_W-1:0] count;
	logic                  full;

	modport snk (input we, input data, output count, output full);
	modport src (output we, output data, input count, input full);
endinterface

//--- src/ramtest_pkg.sv
//--------------------------------------------------
// RAM test types
// Application command opcodes and mover states
//--------------------------------------------------
package ramtest_pkg;

	// Application port command encoding
	typedef enum logic [2:0] {
		APP_WRITE = 3'd0,
		APP_READ  = 3'd1
	} app_cmd_e;

	// Mover FSM
	typedef enum logic [1:0] {
		IDLE,
		WR_CMD,
		WR_DATA,
		RD_CMD
	} mover_state_e;

endpackage

//--- src/ramtest_params.svh
//--------------------------------------------------
// RAM test sizes
// Host word, memory beat and buffer dimensions
//--------------------------------------------------
`ifndef RAMTEST_PARAMS_SVH
`define RAMTEST_PARAMS_SVH

`define RT_HOST_W         32
`define RT_BEAT_W         256
`define RT_WORDS_PER_BEAT 8
`define RT_BLOCK_WORDS    128
`define RT_IN_DEPTH       1024
`define RT_OUT_DEPTH      1024
`define RT_HEADROOM       20
`define RT_ADDR_W         30
`define RT_MEM_BEATS      256

// Derived sizes, kept in step with the values above
`define RT_IN_BEATS       (`RT_IN_DEPTH / `RT_WORDS_PER_BEAT)
`define RT_OUT_BEATS      (`RT_OUT_DEPTH / `RT_WORDS_PER_BEAT)
`define RT_IDX_W          3
`define RT_BUF_PTR_W      7
`define RT_BCNT_W         8
`define RT_WCNT_W         11
// One extra lap bit above the beat address
`define RT_MEM_PTR_W      9

`endif
